// File: filelist.f
hw/clock_pkg.sv
hw/second_tick.sv
hw/time_counter.sv
hw/alarm_match.sv
hw/count_down_timer.sv
hw/clock_interface.sv
hw/clock_top.sv
tests/tb_clock_checks.sv
tests/tb_clock_top.sv

// File: hw/alarm_match.sv
`timescale 1ns/1ps

module alarm_match (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            sec_tick,
  input  logic            alarm_set,
  input  clock_pkg::hms_t alarm_time_in,
  input  logic            alarm_cancel,
  input  clock_pkg::hms_t now_time,
  output clock_pkg::hms_t alarm_time,
  output logic            alarm_ring
);

  logic armed;
  logic hit;

  // only sampled on the stroke, so one match gives one ring
  assign hit = sec_tick && armed && (now_time == alarm_time);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alarm_time <= '0;
      armed      <= 1'b0;
      alarm_ring <= 1'b0;
    end else begin
      if (alarm_cancel) begin
        armed      <= 1'b0;
        alarm_ring <= 1'b0;
      end else if (hit) begin
        alarm_ring <= 1'b1;
      end
      if (alarm_set) begin
        alarm_time <= alarm_time_in;
        armed      <= 1'b1;
      end
    end
  end

  // ring only ever starts from a stroke
  a_ring_on_tick : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(alarm_ring) |-> $past(sec_tick)
  );

endmodule

// File: hw/clock_interface.sv
`timescale 1ns/1ps

module clock_interface (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                mode_btn,
  input  logic                adjust_btn,
  input  logic                inc_btn,
  input  clock_pkg::hms_t     now_time,
  input  clock_pkg::hms_t     alarm_time,
  input  clock_pkg::hms_t     timer_count,
  input  logic                alarm_ring,
  input  logic                timer_ring,
  output logic                time_load,
  output logic                alarm_set,
  output logic                timer_load,
  output clock_pkg::hms_t     edit_value,
  output logic                alarm_cancel,
  output logic                timer_cancel,
  output clock_pkg::display_t display
);

  clock_pkg::disp_page_t  page;
  clock_pkg::edit_field_t field;
  clock_pkg::hms_t        edit_buf;
  clock_pkg::hms_t        page_value;
  clock_pkg::hms_t        shown;
  logic                   any_btn;
  logic                   ringing;
  logic                   editing;

  assign any_btn    = mode_btn | adjust_btn | inc_btn;
  assign ringing    = alarm_ring | timer_ring;
  assign editing    = (field != clock_pkg::FIELD_NONE);
  assign edit_value = edit_buf;

  always_comb begin
    case (page)
      clock_pkg::PAGE_ALARM: page_value = alarm_time;
      clock_pkg::PAGE_TIMER: page_value = timer_count;
      default:               page_value = now_time;
    endcase
  end

  assign shown = editing ? edit_buf : page_value;

  ////////////////////////////////////////
  // page and field fsm
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      page         <= clock_pkg::PAGE_TIME;
      field        <= clock_pkg::FIELD_NONE;
      time_load    <= 1'b0;
      alarm_set    <= 1'b0;
      timer_load   <= 1'b0;
      alarm_cancel <= 1'b0;
      timer_cancel <= 1'b0;
    end else begin
      time_load    <= 1'b0;
      alarm_set    <= 1'b0;
      timer_load   <= 1'b0;
      alarm_cancel <= 1'b0;
      timer_cancel <= 1'b0;
      if (ringing) begin
        // a press only silences while ringing
        alarm_cancel <= any_btn && alarm_ring;
        timer_cancel <= any_btn && timer_ring;
      end else if (adjust_btn) begin
        case (field)
          clock_pkg::FIELD_NONE:   field <= clock_pkg::FIELD_HOUR;
          clock_pkg::FIELD_HOUR:   field <= clock_pkg::FIELD_MINUTE;
          clock_pkg::FIELD_MINUTE: field <= clock_pkg::FIELD_SECOND;
          default: begin
            field      <= clock_pkg::FIELD_NONE;
            time_load  <= (page == clock_pkg::PAGE_TIME);
            alarm_set  <= (page == clock_pkg::PAGE_ALARM);
            timer_load <= (page == clock_pkg::PAGE_TIMER);
          end
        endcase
      end else if (mode_btn && !editing) begin
        case (page)
          clock_pkg::PAGE_TIME:  page <= clock_pkg::PAGE_ALARM;
          clock_pkg::PAGE_ALARM: page <= clock_pkg::PAGE_TIMER;
          default:               page <= clock_pkg::PAGE_TIME;
        endcase
      end
    end
  end

  // edit buffer, loaded on entry and walked by inc
  always_ff @(posedge clk) begin
    if (!ringing && adjust_btn && !editing) begin
      edit_buf <= page_value;
    end else if (!ringing && !adjust_btn && inc_btn) begin
      case (field)
        clock_pkg::FIELD_HOUR:   edit_buf.hour   <= clock_pkg::bcd_inc(edit_buf.hour, 8'h23);
        clock_pkg::FIELD_MINUTE: edit_buf.minute <= clock_pkg::bcd_inc(edit_buf.minute, 8'h59);
        clock_pkg::FIELD_SECOND: edit_buf.second <= clock_pkg::bcd_inc(edit_buf.second, 8'h59);
        default:                 edit_buf        <= edit_buf;
      endcase
    end
  end

  ////////////////////////////////////////
  // display
  ////////////////////////////////////////

  function automatic clock_pkg::display_t layout(
    input clock_pkg::disp_page_t  pg,
    input clock_pkg::hms_t        t,
    input clock_pkg::edit_field_t fld
  );
    clock_pkg::display_t d;
    logic                bh;
    logic                bm;
    logic                bs;
    bh = (fld == clock_pkg::FIELD_HOUR);
    bm = (fld == clock_pkg::FIELD_MINUTE);
    bs = (fld == clock_pkg::FIELD_SECOND);
    d  = '0;
    if (pg == clock_pkg::PAGE_TIME) begin
      // hh-mm-ss
      d[7] = '{blink: bh, code: t.hour[7:4]};
      d[6] = '{blink: bh, code: t.hour[3:0]};
      d[5] = '{blink: 1'b0, code: clock_pkg::CODE_DASH};
      d[4] = '{blink: bm, code: t.minute[7:4]};
      d[3] = '{blink: bm, code: t.minute[3:0]};
      d[2] = '{blink: 1'b0, code: clock_pkg::CODE_DASH};
    end else begin
      // marker, dash, hhmmss
      d[7].code = (pg == clock_pkg::PAGE_ALARM) ? clock_pkg::CODE_ALARM : clock_pkg::CODE_TIMER;
      d[6].code = clock_pkg::CODE_DASH;
      d[5] = '{blink: bh, code: t.hour[7:4]};
      d[4] = '{blink: bh, code: t.hour[3:0]};
      d[3] = '{blink: bm, code: t.minute[7:4]};
      d[2] = '{blink: bm, code: t.minute[3:0]};
    end
    d[1] = '{blink: bs, code: t.second[7:4]};
    d[0] = '{blink: bs, code: t.second[3:0]};
    return d;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      display <= layout(clock_pkg::PAGE_TIME, '0, clock_pkg::FIELD_NONE);
    end else begin
      display <= layout(page, shown, field);
    end
  end

  // commits go to one block at a time
  a_one_commit : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0({time_load, alarm_set, timer_load})
  );

endmodule

// File: hw/clock_pkg.sv
package clock_pkg;

  ////////////////////////////////////////
  // time and display types
  ////////////////////////////////////////

  // two bcd digits per field
  typedef struct packed {
    logic [7:0] hour;
    logic [7:0] minute;
    logic [7:0] second;
  } hms_t;

  typedef struct packed {
    logic       blink;
    logic [3:0] code;
  } led_digit_t;

  // index 7 is the leftmost digit
  typedef led_digit_t [7:0] display_t;

  typedef enum logic [1:0] {
    PAGE_TIME,
    PAGE_ALARM,
    PAGE_TIMER
  } disp_page_t;

  typedef enum logic [1:0] {
    FIELD_NONE,
    FIELD_HOUR,
    FIELD_MINUTE,
    FIELD_SECOND
  } edit_field_t;

  // codes above 9 are symbols
  localparam logic [3:0] CODE_DASH  = 4'd10;
  localparam logic [3:0] CODE_ALARM = 4'd11;
  localparam logic [3:0] CODE_TIMER = 4'd12;

  // two-digit bcd increment, wraps to 00 after max
  function automatic logic [7:0] bcd_inc(input logic [7:0] v, input logic [7:0] max);
    if (v == max) return 8'h00;
    else if (v[3:0] == 4'd9) return {v[7:4] + 4'd1, 4'd0};
    else return {v[7:4], v[3:0] + 4'd1};
  endfunction

endpackage

// File: hw/clock_top.sv
`timescale 1ns/1ps

module clock_top #(
  parameter int unsigned TICK_DIV = 50_000_000
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                mode_btn,
  input  logic                adjust_btn,
  input  logic                inc_btn,
  output clock_pkg::display_t display,
  output logic                alarm_ring,
  output logic                timer_ring
);

  logic            sec_tick;
  logic            time_load;
  logic            alarm_set;
  logic            timer_load;
  logic            alarm_cancel;
  logic            timer_cancel;
  clock_pkg::hms_t edit_value;
  clock_pkg::hms_t now_time;
  clock_pkg::hms_t alarm_time;
  clock_pkg::hms_t timer_count;

  second_tick #(.TICK_DIV(TICK_DIV)) u_second_tick (
    .clk      (clk),
    .rst_n    (rst_n),
    .sec_tick (sec_tick)
  );

  time_counter u_time_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .sec_tick  (sec_tick),
    .time_load (time_load),
    .time_set  (edit_value),
    .now_time  (now_time)
  );

  alarm_match u_alarm_match (
    .clk           (clk),
    .rst_n         (rst_n),
    .sec_tick      (sec_tick),
    .alarm_set     (alarm_set),
    .alarm_time_in (edit_value),
    .alarm_cancel  (alarm_cancel),
    .now_time      (now_time),
    .alarm_time    (alarm_time),
    .alarm_ring    (alarm_ring)
  );

  count_down_timer u_count_down_timer (
    .clk          (clk),
    .rst_n        (rst_n),
    .sec_tick     (sec_tick),
    .timer_load   (timer_load),
    .timer_in     (edit_value),
    .timer_cancel (timer_cancel),
    .timer_count  (timer_count),
    .timer_ring   (timer_ring)
  );

  clock_interface u_clock_interface (
    .clk          (clk),
    .rst_n        (rst_n),
    .mode_btn     (mode_btn),
    .adjust_btn   (adjust_btn),
    .inc_btn      (inc_btn),
    .now_time     (now_time),
    .alarm_time   (alarm_time),
    .timer_count  (timer_count),
    .alarm_ring   (alarm_ring),
    .timer_ring   (timer_ring),
    .time_load    (time_load),
    .alarm_set    (alarm_set),
    .timer_load   (timer_load),
    .edit_value   (edit_value),
    .alarm_cancel (alarm_cancel),
    .timer_cancel (timer_cancel),
    .display      (display)
  );

endmodule

// File: hw/count_down_timer.sv
`timescale 1ns/1ps

module count_down_timer (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            sec_tick,
  input  logic            timer_load,
  input  clock_pkg::hms_t timer_in,
  input  logic            timer_cancel,
  output clock_pkg::hms_t timer_count,
  output logic            timer_ring
);

  logic            running;
  logic            sec_borrow;
  logic            min_borrow;
  clock_pkg::hms_t next_count;

  // two-digit bcd decrement, 00 goes back to max
  function automatic logic [7:0] bcd_dec(input logic [7:0] v, input logic [7:0] max);
    if (v == 8'h00) return max;
    else if (v[3:0] == 4'd0) return {v[7:4] - 4'd1, 4'd9};
    else return {v[7:4], v[3:0] - 4'd1};
  endfunction

  assign sec_borrow = (timer_count.second == 8'h00);
  assign min_borrow = sec_borrow && (timer_count.minute == 8'h00);

  always_comb begin
    next_count        = timer_count;
    next_count.second = bcd_dec(timer_count.second, 8'h59);
    if (sec_borrow) begin
      next_count.minute = bcd_dec(timer_count.minute, 8'h59);
    end
    // a running count is non-zero, so hours never underflow
    if (min_borrow) begin
      next_count.hour = bcd_dec(timer_count.hour, 8'h23);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timer_count <= '0;
      running     <= 1'b0;
      timer_ring  <= 1'b0;
    end else begin
      if (timer_cancel) begin
        timer_ring <= 1'b0;
      end
      if (timer_load) begin
        timer_count <= timer_in;
        running     <= (timer_in != '0);
      end else if (running && sec_tick) begin
        timer_count <= next_count;
        if (next_count == '0) begin
          running    <= 1'b0;
          timer_ring <= 1'b1;
        end
      end
    end
  end

  // a stopped timer holds its count
  a_count_frozen : assert property (
    @(posedge clk) disable iff (!rst_n)
    (!running && !timer_load) |=> $stable(timer_count)
  );

endmodule

// File: hw/second_tick.sv
`timescale 1ns/1ps

module second_tick #(
  parameter int unsigned TICK_DIV = 50_000_000
) (
  input  logic clk,
  input  logic rst_n,
  output logic sec_tick
);

  localparam int unsigned CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [CNT_W-1:0] cnt;
  logic             wrap;

  assign wrap = (cnt == CNT_W'(TICK_DIV - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt      <= '0;
      sec_tick <= 1'b0;
    end else begin
      // stroke lands on the cycle after the wrap
      sec_tick <= wrap;
      cnt      <= wrap ? '0 : cnt + 1'b1;
    end
  end

  // strokes are isolated single cycles
  a_tick_single : assert property (
    @(posedge clk) disable iff (!rst_n)
    (TICK_DIV > 1 && sec_tick) |=> !sec_tick
  );

endmodule

// File: hw/time_counter.sv
`timescale 1ns/1ps

module time_counter (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            sec_tick,
  input  logic            time_load,
  input  clock_pkg::hms_t time_set,
  output clock_pkg::hms_t now_time
);

  logic sec_wrap;
  logic min_wrap;

  // carry out of each stage
  assign sec_wrap = (now_time.second == 8'h59);
  assign min_wrap = (now_time.minute == 8'h59);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      now_time <= '0;
    end else if (time_load) begin
      now_time <= time_set;
    end else if (sec_tick) begin
      now_time.second <= clock_pkg::bcd_inc(now_time.second, 8'h59);
      if (sec_wrap) begin
        now_time.minute <= clock_pkg::bcd_inc(now_time.minute, 8'h59);
        if (min_wrap) begin
          now_time.hour <= clock_pkg::bcd_inc(now_time.hour, 8'h23);
        end
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // every digit stays a legal wall-clock value
  a_time_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    now_time.hour <= 8'h23 && now_time.hour[3:0] <= 4'd9 &&
    now_time.minute <= 8'h59 && now_time.minute[3:0] <= 4'd9 &&
    now_time.second <= 8'h59 && now_time.second[3:0] <= 4'd9
  );

endmodule

// File: tests/tb_clock_checks.sv
`timescale 1ns/1ps

module tb_clock_checks (
  input logic                clk,
  input logic                rst_n,
  input logic                mode_btn,
  input logic                adjust_btn,
  input logic                inc_btn,
  input clock_pkg::display_t display,
  input logic                alarm_ring,
  input logic                timer_ring
);

  int                     errors = 0;
  int unsigned            cyc;
  logic                   tick;
  logic                   ringing;
  clock_pkg::hms_t        m_time;
  clock_pkg::hms_t        m_alarm;
  clock_pkg::hms_t        m_timer;
  clock_pkg::hms_t        m_buf;
  clock_pkg::hms_t        page_val;
  logic                   m_armed;
  logic                   m_aring;
  logic                   m_run;
  logic                   m_tring;
  clock_pkg::disp_page_t  page;
  clock_pkg::edit_field_t field;
  logic                   c_time;
  logic                   c_alarm;
  logic                   c_timer;
  logic                   x_alarm;
  logic                   x_timer;
  clock_pkg::display_t    exp_disp;

  ////////////////////////////////////////
  // reference arithmetic
  ////////////////////////////////////////

  function automatic int val(input logic [7:0] v);
    return v[7:4] * 10 + v[3:0];
  endfunction

  function automatic logic [7:0] enc(input int n);
    return {4'(n / 10), 4'(n % 10)};
  endfunction

  function automatic int to_sec(input clock_pkg::hms_t t);
    return val(t.hour) * 3600 + val(t.minute) * 60 + val(t.second);
  endfunction

  function automatic clock_pkg::hms_t from_sec(input int n);
    clock_pkg::hms_t t;
    t.hour   = enc(n / 3600);
    t.minute = enc((n / 60) % 60);
    t.second = enc(n % 60);
    return t;
  endfunction

  // field step modulo its range
  function automatic logic [7:0] bump(input logic [7:0] v, input int lim);
    return enc((val(v) + 1) % lim);
  endfunction

  function automatic clock_pkg::display_t draw(
    input clock_pkg::disp_page_t  pg,
    input clock_pkg::hms_t        t,
    input clock_pkg::edit_field_t fld
  );
    clock_pkg::display_t d;
    logic [31:0]         codes;
    logic [7:0]          mask;
    logic                tp;
    tp = (pg == clock_pkg::PAGE_TIME);
    if (tp) begin
      codes = {t.hour, clock_pkg::CODE_DASH, t.minute, clock_pkg::CODE_DASH, t.second};
    end else begin
      codes = {(pg == clock_pkg::PAGE_ALARM) ? clock_pkg::CODE_ALARM : clock_pkg::CODE_TIMER,
               clock_pkg::CODE_DASH, t};
    end
    case (fld)
      clock_pkg::FIELD_HOUR:   mask = tp ? 8'b1100_0000 : 8'b0011_0000;
      clock_pkg::FIELD_MINUTE: mask = tp ? 8'b0001_1000 : 8'b0000_1100;
      clock_pkg::FIELD_SECOND: mask = 8'b0000_0011;
      default:                 mask = 8'b0;
    endcase
    for (int i = 0; i < 8; i++) begin
      d[i] = {mask[i], codes[4*i +: 4]};
    end
    return d;
  endfunction

  ////////////////////////////////////////
  // model
  ////////////////////////////////////////

  assign tick    = (cyc != 0) && (cyc % 4 == 0);
  assign ringing = m_aring | m_tring;
  assign page_val = (page == clock_pkg::PAGE_ALARM) ? m_alarm :
                    (page == clock_pkg::PAGE_TIMER) ? m_timer : m_time;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc <= 0;
      {m_time, m_alarm, m_timer, m_buf} <= '0;
      {m_armed, m_aring, m_run, m_tring} <= '0;
      {c_time, c_alarm, c_timer, x_alarm, x_timer} <= '0;
      page     <= clock_pkg::PAGE_TIME;
      field    <= clock_pkg::FIELD_NONE;
      exp_disp <= draw(clock_pkg::PAGE_TIME, '0, clock_pkg::FIELD_NONE);
    end else begin
      cyc <= cyc + 1;
      if (c_time) m_time <= m_buf;
      else if (tick) m_time <= from_sec((to_sec(m_time) + 1) % 86400);
      if (x_alarm) begin
        m_armed <= 1'b0;
        m_aring <= 1'b0;
      end else if (tick && m_armed && m_time == m_alarm) begin
        m_aring <= 1'b1;
      end
      if (c_alarm) begin
        m_alarm <= m_buf;
        m_armed <= 1'b1;
      end
      if (x_timer) m_tring <= 1'b0;
      if (c_timer) begin
        m_timer <= m_buf;
        m_run   <= (m_buf != '0);
      end else if (m_run && tick) begin
        m_timer <= from_sec(to_sec(m_timer) - 1);
        if (to_sec(m_timer) == 1) begin
          m_run   <= 1'b0;
          m_tring <= 1'b1;
        end
      end
      {c_time, c_alarm, c_timer} <= '0;
      x_alarm <= ringing && m_aring && (mode_btn | adjust_btn | inc_btn);
      x_timer <= ringing && m_tring && (mode_btn | adjust_btn | inc_btn);
      if (!ringing && adjust_btn) begin
        if (field == clock_pkg::FIELD_NONE) m_buf <= page_val;
        if (field == clock_pkg::FIELD_SECOND) begin
          field   <= clock_pkg::FIELD_NONE;
          c_time  <= (page == clock_pkg::PAGE_TIME);
          c_alarm <= (page == clock_pkg::PAGE_ALARM);
          c_timer <= (page == clock_pkg::PAGE_TIMER);
        end else begin
          field <= clock_pkg::edit_field_t'(field + 1);
        end
      end else if (!ringing && mode_btn && field == clock_pkg::FIELD_NONE) begin
        page <= (page == clock_pkg::PAGE_TIMER) ? clock_pkg::PAGE_TIME
                                                : clock_pkg::disp_page_t'(page + 1);
      end
      if (!ringing && !adjust_btn && inc_btn) begin
        if (field == clock_pkg::FIELD_HOUR) m_buf.hour <= bump(m_buf.hour, 24);
        if (field == clock_pkg::FIELD_MINUTE) m_buf.minute <= bump(m_buf.minute, 60);
        if (field == clock_pkg::FIELD_SECOND) m_buf.second <= bump(m_buf.second, 60);
      end
      exp_disp <= draw(page, (field != clock_pkg::FIELD_NONE) ? m_buf : page_val, field);
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  a_display : assert property (@(posedge clk) disable iff (!rst_n) display == exp_disp)
    else begin
      errors++;
      $display("** Error at %0t: display expected %h, got %h",
               $time, $sampled(exp_disp), $sampled(display));
    end

  a_alarm_ring : assert property (@(posedge clk) disable iff (!rst_n) alarm_ring == m_aring)
    else begin
      errors++;
      $display("** Error at %0t: alarm_ring expected %b, got %b",
               $time, $sampled(m_aring), $sampled(alarm_ring));
    end

  a_timer_ring : assert property (@(posedge clk) disable iff (!rst_n) timer_ring == m_tring)
    else begin
      errors++;
      $display("** Error at %0t: timer_ring expected %b, got %b",
               $time, $sampled(m_tring), $sampled(timer_ring));
    end

endmodule

// File: tests/tb_clock_top.sv
`timescale 1ns/1ps

module tb_clock_top;

  logic                clk;
  logic                rst_n;
  logic                mode_btn;
  logic                adjust_btn;
  logic                inc_btn;
  clock_pkg::display_t display;
  logic                alarm_ring;
  logic                timer_ring;
  logic [31:0]         lfsr = 32'hc3c6_735d;
  int                  run_errors = 0;
  int                  target;

  clock_top #(.TICK_DIV(4)) DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .mode_btn   (mode_btn),
    .adjust_btn (adjust_btn),
    .inc_btn    (inc_btn),
    .display    (display),
    .alarm_ring (alarm_ring),
    .timer_ring (timer_ring)
  );

  tb_clock_checks chk (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // taps 32 22 2 1
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  function automatic int rand_upto(input int n, input int max);
    int v;
    v = rand_bits(n);
    while (v > max) v = rand_bits(n);
    return v;
  endfunction

  task automatic end_run;
    $display("closing: %0d assertion errors, %0d run errors", chk.errors, run_errors);
    if (chk.errors == 0 && run_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  // registered outputs answer a press one cycle after it lands
  task automatic wait_response(
    input clock_pkg::display_t disp0,
    input logic                aring0,
    input logic                tring0
  );
    int n;
    n = 0;
    while (n < 8 && display == disp0 && alarm_ring == aring0 && timer_ring == tring0) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (display == disp0 && alarm_ring == aring0 && timer_ring == tring0) begin
      $display("timeout: display and rings never answered a press");
      run_errors++;
    end
  endtask

  task automatic press_mode;
    clock_pkg::display_t disp0;
    logic                aring0;
    logic                tring0;
    @(posedge clk);
    #1;
    disp0    = display;
    aring0   = alarm_ring;
    tring0   = timer_ring;
    mode_btn = 1'b1;
    @(posedge clk);
    #1;
    mode_btn = 1'b0;
    wait_response(disp0, aring0, tring0);
  endtask

  task automatic press_adjust;
    clock_pkg::display_t disp0;
    logic                aring0;
    logic                tring0;
    @(posedge clk);
    #1;
    disp0      = display;
    aring0     = alarm_ring;
    tring0     = timer_ring;
    adjust_btn = 1'b1;
    @(posedge clk);
    #1;
    adjust_btn = 1'b0;
    wait_response(disp0, aring0, tring0);
  endtask

  task automatic press_inc(input int n);
    clock_pkg::display_t disp0;
    logic                aring0;
    logic                tring0;
    @(posedge clk);
    #1;
    disp0  = display;
    aring0 = alarm_ring;
    tring0 = timer_ring;
    for (int i = 0; i < n; i++) begin
      inc_btn = 1'b1;
      @(posedge clk);
      #1;
    end
    inc_btn = 1'b0;
    if (n > 0) begin
      wait_response(disp0, aring0, tring0);
    end
  endtask

  task automatic wait_ring(input logic use_timer, input int limit);
    int n;
    n = 0;
    while (n < limit && !(use_timer ? timer_ring : alarm_ring)) begin
      @(posedge clk);
      n++;
    end
    if (!(use_timer ? timer_ring : alarm_ring)) begin
      $display("timeout: %s ring never rose", use_timer ? "timer" : "alarm");
      run_errors++;
    end
  endtask

  // model hour comes back to 00 once the 23:59 commit rolls over
  task automatic wait_rollover(input int limit);
    int n;
    n = 0;
    while (n < limit && chk.m_time.hour != 8'h00) begin
      @(posedge clk);
      n++;
    end
    if (chk.m_time.hour != 8'h00) begin
      $display("timeout: clock never rolled over to midnight");
      run_errors++;
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    mode_btn   = 1'b0;
    adjust_btn = 1'b0;
    inc_btn    = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (20) @(posedge clk);

    // page walk
    repeat (3) press_mode();

    // time edit with hour and minute wrap
    press_adjust();
    press_inc(47);
    press_adjust();
    press_inc(119);
    press_adjust();
    press_inc(rand_upto(6, 59));
    press_adjust();
    wait_rollover(300);

    // alarm a few seconds ahead
    target = chk.m_time.second[7:4] * 10 + chk.m_time.second[3:0] + 12;
    press_mode();
    repeat (3) press_adjust();
    press_inc(target);
    press_adjust();
    wait_ring(1'b0, 200);
    repeat (8) @(posedge clk);
    press_mode();
    press_mode();

    // short countdown
    repeat (3) press_adjust();
    press_inc(3 + rand_upto(3, 6));
    press_adjust();
    wait_ring(1'b1, 100);
    repeat (6) @(posedge clk);
    press_inc(1);
    repeat (4) @(posedge clk);
    end_run();
  end

endmodule
